/* arch_regfile.sv */
////////////////////////////////////////
// arch_regfile
// 32-word architectural registers, written
// at retire, two combinational reads
////////////////////////////////////////

module arch_regfile (
    input  logic             clock,
    input  logic             reset,
    input  ooo_pkg::retire_t retire,
    input  ooo_pkg::reg_idx_t src_reg_a,
    input  ooo_pkg::reg_idx_t src_reg_b,
    output ooo_pkg::word_t   value_a,
    output ooo_pkg::word_t   value_b
);

    ooo_pkg::word_t regs [ooo_pkg::num_regs];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.dest_valid) begin
            regs[retire.dest_reg] <= retire.dest_value;
        end
    end

    // x0 is hardwired
    assign value_a = (src_reg_a == ooo_pkg::zero_reg) ? '0 : regs[src_reg_a];
    assign value_b = (src_reg_b == ooo_pkg::zero_reg) ? '0 : regs[src_reg_b];

    // the buffer must never retire a write to x0
    no_x0_write: assert property (
        @(posedge clock) disable iff (reset)
        retire.dest_valid |-> retire.dest_reg != ooo_pkg::zero_reg
    );

endmodule

/* commit_stage.sv */
////////////////////////////////////////
// commit_stage
// reorder buffer, rename map, register
// file and operand reader
////////////////////////////////////////

module commit_stage (
    input  logic               clock,
    input  logic               reset,
    input  ooo_pkg::dispatch_t dispatch,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               store_ack,
    output logic               rob_full,
    output ooo_pkg::rob_tag_t  dispatch_tag,
    output ooo_pkg::operand_t  src_a,
    output ooo_pkg::operand_t  src_b,
    output ooo_pkg::retire_t   retire,
    output logic               store_commit,
    output logic               squash,
    output ooo_pkg::word_t     target_pc,
    output logic               halt
);

    ooo_pkg::operand_t map_a;
    ooo_pkg::operand_t map_b;
    ooo_pkg::operand_t rob_a;
    ooo_pkg::operand_t rob_b;
    ooo_pkg::rob_tag_t read_tag_a;
    ooo_pkg::rob_tag_t read_tag_b;
    ooo_pkg::word_t    reg_a;
    ooo_pkg::word_t    reg_b;

    // the tail tag is the producer of the new destination
    rob u_rob (
        .clock(clock), .reset(reset),
        .dispatch(dispatch), .cdb(cdb), .store_ack(store_ack),
        .read_tag_a(read_tag_a), .read_tag_b(read_tag_b),
        .read_a(rob_a), .read_b(rob_b),
        .tail(dispatch_tag), .rob_full(rob_full), .retire(retire),
        .store_commit(store_commit), .squash(squash), .halt(halt),
        .target_pc(target_pc)
    );

    rename_map u_rename_map (
        .clock(clock), .reset(reset),
        .dispatch(dispatch), .rob_full(rob_full), .tail(dispatch_tag),
        .retire(retire), .squash(squash),
        .map_a(map_a), .map_b(map_b)
    );

    arch_regfile u_arch_regfile (
        .clock(clock), .reset(reset), .retire(retire),
        .src_reg_a(dispatch.src_reg_a), .src_reg_b(dispatch.src_reg_b),
        .value_a(reg_a), .value_b(reg_b)
    );

    operand_read u_operand_read (
        .map_a(map_a), .map_b(map_b), .rob_a(rob_a), .rob_b(rob_b),
        .reg_a(reg_a), .reg_b(reg_b),
        .read_tag_a(read_tag_a), .read_tag_b(read_tag_b),
        .src_a(src_a), .src_b(src_b)
    );

endmodule

/* commit_stage_vectors.svh */
////////////////////////////////////////
// commit stage vectors
// stimulus rows and expected flags for
// the commit stage testbench
////////////////////////////////////////

`ifndef commit_stage_vectors_svh
`define commit_stage_vectors_svh

// ctl {valid, branch, pred taken, store, halt}, io {cdb valid, taken, store_ack}
// exp {full, retire, dest valid, store commit, squash, halt}, rdy and skip {a, b}
localparam int n_rows = 25;

localparam row_t rows [n_rows] = '{
    // ctl       dest   sa     sb     io      ctag   exp        rdy    a_tag  b_tag  skip
    // three producers, completed youngest first
    '{5'b10000, 5'd1,  5'd0,  5'd0,  3'b000, 3'd0,  6'b000000, 2'b11, 3'd0,  3'd0,  2'b00},
    '{5'b10000, 5'd2,  5'd1,  5'd5,  3'b000, 3'd0,  6'b000000, 2'b01, 3'd0,  3'd0,  2'b00},
    '{5'b10000, 5'd3,  5'd2,  5'd1,  3'b000, 3'd0,  6'b000000, 2'b00, 3'd1,  3'd0,  2'b00},
    '{5'b00000, 5'd0,  5'd3,  5'd2,  3'b100, 3'd2,  6'b000000, 2'b00, 3'd2,  3'd1,  2'b00},
    '{5'b00000, 5'd0,  5'd3,  5'd2,  3'b100, 3'd1,  6'b000000, 2'b10, 3'd0,  3'd1,  2'b00},
    '{5'b00000, 5'd0,  5'd2,  5'd1,  3'b100, 3'd0,  6'b000000, 2'b10, 3'd0,  3'd0,  2'b00},
    '{5'b00000, 5'd0,  5'd1,  5'd0,  3'b000, 3'd0,  6'b011000, 2'b11, 3'd0,  3'd0,  2'b00},
    '{5'b00000, 5'd0,  5'd1,  5'd2,  3'b000, 3'd0,  6'b011000, 2'b11, 3'd0,  3'd0,  2'b00},
    // fill the buffer, store, halt and a branch among the eight
    '{5'b10000, 5'd4,  5'd3,  5'd0,  3'b000, 3'd0,  6'b011000, 2'b11, 3'd0,  3'd0,  2'b00},
    '{5'b10010, 5'd0,  5'd4,  5'd0,  3'b000, 3'd0,  6'b000000, 2'b01, 3'd3,  3'd0,  2'b00},
    '{5'b10001, 5'd0,  5'd0,  5'd0,  3'b000, 3'd0,  6'b000000, 2'b11, 3'd0,  3'd0,  2'b11},
    '{5'b11000, 5'd0,  5'd0,  5'd0,  3'b000, 3'd0,  6'b000000, 2'b11, 3'd0,  3'd0,  2'b11},
    '{5'b10000, 5'd6,  5'd0,  5'd0,  3'b000, 3'd0,  6'b000000, 2'b11, 3'd0,  3'd0,  2'b11},
    '{5'b10000, 5'd7,  5'd0,  5'd0,  3'b000, 3'd0,  6'b000000, 2'b11, 3'd0,  3'd0,  2'b11},
    '{5'b10000, 5'd8,  5'd0,  5'd0,  3'b000, 3'd0,  6'b000000, 2'b11, 3'd0,  3'd0,  2'b11},
    '{5'b10000, 5'd8,  5'd0,  5'd0,  3'b000, 3'd0,  6'b000000, 2'b11, 3'd0,  3'd0,  2'b11},
    // ninth dispatch while full
    '{5'b10000, 5'd9,  5'd6,  5'd4,  3'b100, 3'd7,  6'b100000, 2'b00, 3'd7,  3'd3,  2'b00},
    '{5'b00000, 5'd0,  5'd6,  5'd4,  3'b100, 3'd3,  6'b100000, 2'b10, 3'd0,  3'd3,  2'b00},
    '{5'b00000, 5'd0,  5'd4,  5'd0,  3'b100, 3'd4,  6'b111000, 2'b11, 3'd0,  3'd0,  2'b00},
    // store waits for its ack
    '{5'b00000, 5'd0,  5'd0,  5'd0,  3'b110, 3'd6,  6'b000000, 2'b11, 3'd0,  3'd0,  2'b11},
    '{5'b00000, 5'd0,  5'd0,  5'd0,  3'b001, 3'd0,  6'b010100, 2'b11, 3'd0,  3'd0,  2'b11},
    '{5'b00000, 5'd0,  5'd0,  5'd0,  3'b000, 3'd0,  6'b010001, 2'b11, 3'd0,  3'd0,  2'b11},
    // squash drops the dispatch beside it
    '{5'b10000, 5'd10, 5'd0,  5'd0,  3'b000, 3'd0,  6'b010010, 2'b11, 3'd0,  3'd0,  2'b11},
    '{5'b00000, 5'd0,  5'd6,  5'd4,  3'b000, 3'd0,  6'b000000, 2'b11, 3'd0,  3'd0,  2'b00},
    '{5'b00000, 5'd0,  5'd10, 5'd8,  3'b000, 3'd0,  6'b000000, 2'b11, 3'd0,  3'd0,  2'b00}
};

`endif

/* commit_stage_tb.sv */
////////////////////////////////////////
// commit_stage_tb
// table driven testbench with a small
// reference model of buffer and registers
////////////////////////////////////////

module commit_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam ooo_pkg::word_t jump_target = 32'h0000_2000;

    typedef struct packed {
        logic [4:0]        ctl;
        ooo_pkg::reg_idx_t dest;
        ooo_pkg::reg_idx_t sa;
        ooo_pkg::reg_idx_t sb;
        logic [2:0]        io;
        ooo_pkg::rob_tag_t ctag;
        logic [5:0]        exp;
        logic [1:0]        rdy;
        ooo_pkg::rob_tag_t a_tag;
        ooo_pkg::rob_tag_t b_tag;
        logic [1:0]        skip;
    } row_t;

    // one in-flight instruction of the model
    typedef struct {
        ooo_pkg::rob_tag_t tag;
        ooo_pkg::reg_idx_t dest;
        ooo_pkg::word_t    pc;
        ooo_pkg::word_t    value;
        logic              taken;
    } model_t;

`include "commit_stage_vectors.svh"

    logic               clock;
    logic               reset;
    ooo_pkg::dispatch_t dispatch;
    ooo_pkg::cdb_t      cdb;
    logic               store_ack;
    logic               rob_full;
    ooo_pkg::rob_tag_t  dispatch_tag;
    ooo_pkg::operand_t  src_a;
    ooo_pkg::operand_t  src_b;
    ooo_pkg::retire_t   retire;
    logic               store_commit;
    logic               squash;
    ooo_pkg::word_t     target_pc;
    logic               halt;

    model_t             q [$];
    ooo_pkg::word_t     regs [ooo_pkg::num_regs];
    ooo_pkg::rob_tag_t  model_tail;
    ooo_pkg::word_t     cdb_value;
    int                 errors;
    int                 row_index;

    commit_stage u_commit_stage (
        .clock(clock), .reset(reset),
        .dispatch(dispatch), .cdb(cdb), .store_ack(store_ack),
        .rob_full(rob_full), .dispatch_tag(dispatch_tag),
        .src_a(src_a), .src_b(src_b), .retire(retire),
        .store_commit(store_commit), .squash(squash),
        .target_pc(target_pc), .halt(halt)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic ooo_pkg::word_t row_pc(int i);
        return 32'h0000_1000 + ooo_pkg::word_t'(i * 4);
    endfunction

    // youngest producer in flight, else the register
    function automatic ooo_pkg::word_t expected_value(ooo_pkg::reg_idx_t src);
        ooo_pkg::word_t v;
        v = regs[src];
        if (src != ooo_pkg::zero_reg) begin
            foreach (q[i]) begin
                if (q[i].dest == src) begin
                    v = q[i].value;
                end
            end
        end
        return v;
    endfunction

    task automatic report_mismatch(string msg);
        errors++;
        $display("MISMATCH @%0t ns row %0d: %s", $time, row_index, msg);
    endtask

    task automatic apply_row(row_t r);
        ooo_pkg::word_t pc;
        pc = row_pc(row_index);
        cdb_value = r.io[2] ? ooo_pkg::word_t'($urandom) : '0;
        dispatch = '{r.ctl[4], pc, r.ctl[2] ? jump_target : pc + 32'd4, r.dest, r.sa, r.sb,
                     r.ctl[3], r.ctl[2], r.ctl[1], r.ctl[0]};
        cdb = '{r.io[2], r.ctag, cdb_value, r.io[1], jump_target};
        store_ack = r.io[0];
    endtask

    task automatic check_operand(string name, ooo_pkg::operand_t got, logic rdy,
                                 ooo_pkg::rob_tag_t tag, ooo_pkg::reg_idx_t src);
        if (got.ready !== rdy) begin
            report_mismatch($sformatf("%s ready %b, expected %b", name, got.ready, rdy));
        end else if (rdy && got.value !== expected_value(src)) begin
            report_mismatch($sformatf("%s value %h, expected %h", name, got.value,
                                      expected_value(src)));
        end else if (!rdy && got.tag !== tag) begin
            report_mismatch($sformatf("%s tag %0d, expected %0d", name, got.tag, tag));
        end
    endtask

    task automatic check_row(row_t r);
        logic [5:0]     flags;
        ooo_pkg::word_t target;
        flags = {rob_full, retire.valid, retire.dest_valid, store_commit, squash, halt};
        if (flags !== r.exp) begin
            report_mismatch($sformatf("flags %b, expected %b", flags, r.exp));
        end
        if (dispatch_tag !== model_tail) begin
            report_mismatch($sformatf("dispatch_tag %0d, expected %0d", dispatch_tag, model_tail));
        end
        if (r.exp[4] && q.size() == 0) begin
            errors++;
            $display("row %0d expects a retirement but the model buffer is empty", row_index);
        end else if (r.exp[4]) begin
            if (retire.tag !== q[0].tag) begin
                report_mismatch($sformatf("retire tag %0d, expected %0d",
                                          retire.tag, q[0].tag));
            end
            if (retire.dest_reg !== q[0].dest) begin
                report_mismatch($sformatf("retire dest x%0d, expected x%0d",
                                          retire.dest_reg, q[0].dest));
            end
            if (r.exp[3] && retire.dest_value !== q[0].value) begin
                report_mismatch($sformatf("retire value %h, expected %h",
                                          retire.dest_value, q[0].value));
            end
            target = q[0].taken ? jump_target : q[0].pc + 32'd4;
            if (r.exp[1] && target_pc !== target) begin
                report_mismatch($sformatf("target_pc %h, expected %h", target_pc, target));
            end
        end
        if (!r.skip[1]) begin
            check_operand("src_a", src_a, r.rdy[1], r.a_tag, r.sa);
        end
        if (!r.skip[0]) begin
            check_operand("src_b", src_b, r.rdy[0], r.b_tag, r.sb);
        end
    endtask

    ////////////////////////////////////////
    // model state at the rising edge
    task automatic update_model(row_t r);
        model_t e;
        if (r.exp[4] && q.size() > 0) begin
            if (r.exp[3]) begin
                regs[q[0].dest] = q[0].value;
            end
            q.delete(0);
        end
        foreach (q[i]) begin
            if (r.io[2] && q[i].tag == r.ctag) begin
                q[i].value = cdb_value;
                q[i].taken = r.io[1];
            end
        end
        if (r.exp[1]) begin
            q.delete();
            model_tail = '0;
        end else if (r.ctl[4] && !r.exp[5]) begin
            e = '{model_tail, r.dest, row_pc(row_index), '0, 1'b0};
            q.push_back(e);
            model_tail = model_tail + ooo_pkg::rob_tag_t'(1);
        end
    endtask

    initial begin
        void'($urandom(32'h8d4f));
        errors     = 0;
        row_index  = 0;
        model_tail = '0;
        reset      = 1'b1;
        dispatch   = '0;
        cdb        = '0;
        store_ack  = 1'b0;
        cdb_value  = '0;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (row_index = 0; row_index < n_rows; row_index++) begin
            @(negedge clock);
            apply_row(rows[row_index]);
            #1;
            check_row(rows[row_index]);
            update_model(rows[row_index]);
        end
        $display("rows applied %0d, errors %0d", n_rows, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(n_rows * 20 + 200);
        $display("timeout: the stimulus loop did not reach its end");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* files.f */
+incdir+.
ooo_pkg.sv
rob.sv
rename_map.sv
arch_regfile.sv
operand_read.sv
commit_stage.sv
commit_stage_tb.sv

/* ooo_pkg.sv */
////////////////////////////////////////
// ooo_pkg
// sizes, vector types and packed structs
// shared by the in-order commit stage
////////////////////////////////////////

package ooo_pkg;

    // sizes
    localparam int rob_size = 8;
    localparam int xlen     = 32;
    localparam int num_regs = 32;
    localparam int tag_w    = $clog2(rob_size);
    localparam int reg_w    = $clog2(num_regs);

    typedef logic [tag_w-1:0] rob_tag_t;
    typedef logic [tag_w:0]   rob_count_t;
    typedef logic [reg_w-1:0] reg_idx_t;
    typedef logic [xlen-1:0]  word_t;

    // never mapped, always reads as zero
    localparam reg_idx_t zero_reg = '0;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    pred_npc;
        reg_idx_t dest_reg;
        reg_idx_t src_reg_a;
        reg_idx_t src_reg_b;
        logic     is_branch;
        logic     predicted_taken;
        logic     is_store;
        logic     is_halt;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
        logic     actual_taken;
        word_t    actual_target;
    } cdb_t;

    ////////////////////////////////////////
    // one buffer slot
    typedef struct packed {
        logic     valid;
        logic     ready;
        word_t    pc;
        word_t    pred_npc;
        reg_idx_t dest_reg;
        word_t    value;
        logic     is_branch;
        logic     predicted_taken;
        logic     mispredict;
        word_t    branch_target;
        logic     is_store;
        logic     is_halt;
    } rob_entry_t;

    typedef struct packed {
        logic     valid;
        logic     dest_valid;
        reg_idx_t dest_reg;
        word_t    dest_value;
        rob_tag_t tag;
    } retire_t;

    // also used as a map entry, ready then means mapped
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        word_t    value;
    } operand_t;

endpackage

/* operand_read.sv */
////////////////////////////////////////
// operand_read
// picks each source from the register
// file, a finished entry, or a tag
////////////////////////////////////////

module operand_read (
    input  ooo_pkg::operand_t map_a,
    input  ooo_pkg::operand_t map_b,
    input  ooo_pkg::operand_t rob_a,
    input  ooo_pkg::operand_t rob_b,
    input  ooo_pkg::word_t    reg_a,
    input  ooo_pkg::word_t    reg_b,
    output ooo_pkg::rob_tag_t read_tag_a,
    output ooo_pkg::rob_tag_t read_tag_b,
    output ooo_pkg::operand_t src_a,
    output ooo_pkg::operand_t src_b
);

    function automatic ooo_pkg::operand_t pick(ooo_pkg::operand_t map,
                                               ooo_pkg::operand_t from_rob,
                                               ooo_pkg::word_t    from_reg);
        ooo_pkg::operand_t op;
        op.tag = map.tag;
        if (!map.ready) begin
            // no producer in flight
            op.ready = 1'b1;
            op.value = from_reg;
        end else if (from_rob.ready) begin
            op.ready = 1'b1;
            op.value = from_rob.value;
        end else begin
            // wait on the tag
            op.ready = 1'b0;
            op.value = '0;
        end
        return op;
    endfunction

    assign read_tag_a = map_a.tag;
    assign read_tag_b = map_b.tag;

    assign src_a = pick(map_a, rob_a, reg_a);
    assign src_b = pick(map_b, rob_b, reg_b);

endmodule

/* rename_map.sv */
////////////////////////////////////////
// rename_map
// per-register producer tags, set at
// dispatch and cleared at retire or squash
////////////////////////////////////////

module rename_map (
    input  logic               clock,
    input  logic               reset,
    input  ooo_pkg::dispatch_t dispatch,
    input  logic               rob_full,
    input  ooo_pkg::rob_tag_t  tail,
    input  ooo_pkg::retire_t   retire,
    input  logic               squash,
    output ooo_pkg::operand_t  map_a,
    output ooo_pkg::operand_t  map_b
);

    // register 0 has no slot
    logic              map_valid [1:ooo_pkg::num_regs-1];
    ooo_pkg::rob_tag_t map_tag   [1:ooo_pkg::num_regs-1];
    logic              accept;

    // reads see the map before this cycle's dispatch
    always_comb begin
        map_a = '0;
        map_b = '0;
        if (dispatch.src_reg_a != ooo_pkg::zero_reg) begin
            map_a.ready = map_valid[dispatch.src_reg_a];
            map_a.tag   = map_tag[dispatch.src_reg_a];
        end
        if (dispatch.src_reg_b != ooo_pkg::zero_reg) begin
            map_b.ready = map_valid[dispatch.src_reg_b];
            map_b.tag   = map_tag[dispatch.src_reg_b];
        end
    end

    assign accept = dispatch.valid && !rob_full && !squash;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            for (int r = 1; r < ooo_pkg::num_regs; r++) begin
                map_valid[r] <= 1'b0;
            end
        end else begin
            for (int r = 1; r < ooo_pkg::num_regs; r++) begin
                if (accept && (dispatch.dest_reg == ooo_pkg::reg_idx_t'(r))) begin
                    map_valid[r] <= 1'b1;
                    map_tag[r]   <= tail;
                end else if (retire.dest_valid &&
                             (retire.dest_reg == ooo_pkg::reg_idx_t'(r)) &&
                             map_valid[r] && (map_tag[r] == retire.tag)) begin
                    // only the newest producer clears its own mapping
                    map_valid[r] <= 1'b0;
                end
            end
        end
    end

endmodule

/* rob.sv */
////////////////////////////////////////
// rob
// 8-entry circular reorder buffer with
// dispatch, completion and in-order retire
////////////////////////////////////////

module rob (
    input  logic               clock,
    input  logic               reset,
    input  ooo_pkg::dispatch_t dispatch,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               store_ack,
    input  ooo_pkg::rob_tag_t  read_tag_a,
    input  ooo_pkg::rob_tag_t  read_tag_b,
    output ooo_pkg::operand_t  read_a,
    output ooo_pkg::operand_t  read_b,
    output ooo_pkg::rob_tag_t  tail,
    output logic               rob_full,
    output ooo_pkg::retire_t   retire,
    output logic               store_commit,
    output logic               squash,
    output logic               halt,
    output ooo_pkg::word_t     target_pc
);

    ooo_pkg::rob_entry_t entries [ooo_pkg::rob_size];
    ooo_pkg::rob_tag_t   head;
    ooo_pkg::rob_count_t count;

    ooo_pkg::rob_entry_t head_entry;
    ooo_pkg::rob_entry_t new_entry;
    ooo_pkg::rob_entry_t cdb_entry;
    ooo_pkg::word_t      cdb_target;
    logic                cdb_hit;
    logic                cdb_mispredict;
    logic                accept;
    logic                retire_ok;

    // source read ports, ready only once the producer has completed
    always_comb begin
        read_a.ready = entries[read_tag_a].valid && entries[read_tag_a].ready;
        read_a.tag   = read_tag_a;
        read_a.value = entries[read_tag_a].value;
        read_b.ready = entries[read_tag_b].valid && entries[read_tag_b].ready;
        read_b.tag   = read_tag_b;
        read_b.value = entries[read_tag_b].value;
    end

    assign rob_full = (count == ooo_pkg::rob_count_t'(ooo_pkg::rob_size));
    assign accept   = dispatch.valid && !rob_full && !squash;

    ////////////////////////////////////////
    // dispatch entry
    always_comb begin
        new_entry                 = '0;
        new_entry.valid           = 1'b1;
        // halt has nothing to wait for
        new_entry.ready           = dispatch.is_halt;
        new_entry.pc              = dispatch.pc;
        new_entry.pred_npc        = dispatch.pred_npc;
        new_entry.dest_reg        = dispatch.dest_reg;
        new_entry.is_branch       = dispatch.is_branch;
        new_entry.predicted_taken = dispatch.predicted_taken;
        new_entry.is_store        = dispatch.is_store;
        new_entry.is_halt         = dispatch.is_halt;
    end

    ////////////////////////////////////////
    // completion and mispredict decision
    assign cdb_entry  = entries[cdb.tag];
    assign cdb_hit    = cdb.valid && cdb_entry.valid;
    assign cdb_target = cdb.actual_taken ? cdb.actual_target
                                         : cdb_entry.pc + ooo_pkg::word_t'(4);

    // wrong direction, or taken to the wrong place
    assign cdb_mispredict = cdb_entry.is_branch &&
                            ((cdb.actual_taken != cdb_entry.predicted_taken) ||
                             (cdb.actual_taken && (cdb.actual_target != cdb_entry.pred_npc)));

    ////////////////////////////////////////
    // retire
    assign head_entry = entries[head];

    // an unacknowledged store blocks the head
    assign retire_ok = head_entry.valid && head_entry.ready &&
                       (!head_entry.is_store || store_ack);

    assign retire.valid      = retire_ok;
    assign retire.dest_valid = retire_ok && !head_entry.is_store && !head_entry.is_halt &&
                               (head_entry.dest_reg != ooo_pkg::zero_reg);
    assign retire.dest_reg   = head_entry.dest_reg;
    assign retire.dest_value = head_entry.value;
    assign retire.tag        = head;

    assign store_commit = retire_ok && head_entry.is_store;
    assign halt         = retire_ok && head_entry.is_halt;
    assign squash       = retire_ok && head_entry.is_branch && head_entry.mispredict;
    assign target_pc    = head_entry.branch_target;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ooo_pkg::rob_size; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (accept) begin
                entries[tail] <= new_entry;
                tail          <= tail + ooo_pkg::rob_tag_t'(1);
            end
            if (cdb_hit) begin
                entries[cdb.tag].ready         <= 1'b1;
                entries[cdb.tag].value         <= cdb.value;
                entries[cdb.tag].mispredict    <= cdb_mispredict;
                entries[cdb.tag].branch_target <= cdb_target;
            end
            if (retire_ok) begin
                entries[head].valid <= 1'b0;
                head                <= head + ooo_pkg::rob_tag_t'(1);
            end
            // dispatch and retire together leave the count alone
            case ({accept, retire_ok})
                2'b10:   count <= count + ooo_pkg::rob_count_t'(1);
                2'b01:   count <= count - ooo_pkg::rob_count_t'(1);
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////
    // checks
    count_in_range: assert property (
        @(posedge clock) disable iff (reset)
        count <= ooo_pkg::rob_count_t'(ooo_pkg::rob_size)
    );

    // a full buffer takes nothing, so the tail stays put
    full_holds_tail: assert property (
        @(posedge clock) disable iff (reset)
        rob_full && !squash |=> tail == $past(tail)
    );

endmodule
